//--- bubsys_video_pkg.sv
package bubsys_video_pkg;

    ////////////////////
    // Constants

    localparam int CEN_PHASES = 6;                // 18M enables per 6M pixel pair

    localparam logic [8:0] H_FIRST = 9'd128;      // First H count after wrap
    localparam logic [8:0] H_LAST  = 9'd511;      // Last H count of a line
    localparam logic [7:0] V_LAST  = 8'd255;      // Last line of a frame

    localparam int SCROLL_AW   = 11;              // 2k x 8 scroll RAM
    localparam int VRAM_AW     = 12;              // 4k x 16 VRAM1
    localparam int TILE_CODE_W = 11;
    localparam int DRAM_AW     = 8;               // Character DRAM row/column bus

    ////////////////////
    // Enums

    // Six 18M periods per two pixels
    typedef enum logic [2:0]
    {
        PH0 = 3'd0,
        PH1 = 3'd1,
        PH2 = 3'd2,
        PH3 = 3'd3,
        PH4 = 3'd4,
        PH5 = 3'd5
    } cen_phase_e;

    // Owner of a shared RAM slot, follows H bit 0
    typedef enum logic
    {
        OWNER_CPU = 1'b0,
        OWNER_GFX = 1'b1
    } bus_owner_e;

    ////////////////////
    // Bundles

    typedef struct packed
    {
        logic clk9m_pcen_n;    // All active low
        logic clk9m_ncen_n;
        logic clk6m_pcen_n;    // Pixel clock rising edge
        logic clk6m_ncen_n;
    } cen_t;

    typedef struct packed
    {
        logic [8:0] abs_h;
        logic [7:0] abs_v;
        logic [7:0] flip_h;    // Low 8 bits of H XOR hflip
        logic [7:0] flip_v;
    } beam_t;

    typedef struct packed
    {
        logic time1;           // Read latch enable, high active
        logic time2;           // Write enable, low active
        logic vrtime;          // VRAM graphics read, low active
        logic champx;          // 1 = row, 0 = column
    } mem_timing_t;

    typedef struct packed
    {
        logic [15:0] addr;
        logic [15:0] wdata;
        logic        rw;       // 1 = read
        logic        uds_n;
        logic        lds_n;
    } cpu_bus_t;

endpackage

//--- bubsys_clock_enables.sv
`timescale 1ns/1ps

module bubsys_clock_enables
    import bubsys_video_pkg::*;
(
    input  logic i_EMU_MCLK,
    input  logic i_arst_n,
    input  logic i_EMU_CLK18MNCEN_n,   // One MCLK low in every two
    output cen_t o_cen,
    output logic o_ref_6m              // Registered 6M phase for TIME1
);

    cen_phase_e phase_q;
    logic [3:0] pattern_q;             // {9P, 9N, 6P, 6N}, 0 = active

    // Phase counter, wraps PH5 -> PH0
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
            phase_q <= PH5;
        else if (!i_EMU_CLK18MNCEN_n)
        begin
            if (int'(phase_q) == CEN_PHASES - 1)
                phase_q <= PH0;
            else
                phase_q <= cen_phase_e'(phase_q + 3'd1);
        end
    end

    // Enable pattern for the next 18M period
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
            pattern_q <= 4'b1111;          // Everything idle
        else if (!i_EMU_CLK18MNCEN_n)
        begin
            case (phase_q)
                PH0:     pattern_q <= 4'b0110;
                PH1:     pattern_q <= 4'b1001;
                PH2:     pattern_q <= 4'b0111;
                PH3:     pattern_q <= 4'b1010;
                PH4:     pattern_q <= 4'b0101;
                PH5:     pattern_q <= 4'b1011;
                default: pattern_q <= 4'b1111;
            endcase
        end
    end

    // Gate with 18M enable so each strobe is a single MCLK
    assign o_cen.clk9m_pcen_n = pattern_q[3] | i_EMU_CLK18MNCEN_n;
    assign o_cen.clk9m_ncen_n = pattern_q[2] | i_EMU_CLK18MNCEN_n;
    assign o_cen.clk6m_pcen_n = pattern_q[1] | i_EMU_CLK18MNCEN_n;
    assign o_cen.clk6m_ncen_n = pattern_q[0] | i_EMU_CLK18MNCEN_n;

    assign o_ref_6m = pattern_q[1];    // Low for one 18M period per pixel

    // 9M rising and falling edges never share a strobe
    a_9m_exclusive : assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
        !(!o_cen.clk9m_pcen_n && !o_cen.clk9m_ncen_n));

endmodule

//--- bubsys_beam_counter.sv
`timescale 1ns/1ps

module bubsys_beam_counter
    import bubsys_video_pkg::*;
(
    input  logic  i_EMU_MCLK,
    input  logic  i_arst_n,
    input  cen_t  i_cen,
    input  logic  i_hflip,
    input  logic  i_vflip,
    output beam_t o_beam
);

    logic [8:0] h_q;
    logic [7:0] v_q;
    logic       h_wrap;

    assign h_wrap = (h_q == H_LAST);

    ////////////////////
    // H/V counters

    // H runs 128..511, V steps at H wrap
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            h_q <= H_FIRST;
            v_q <= 8'd0;
        end
        else if (!i_cen.clk6m_pcen_n)      // One pixel per 6M rising edge
        begin
            if (h_wrap)
            begin
                h_q <= H_FIRST;
                if (v_q == V_LAST)
                    v_q <= 8'd0;           // New frame
                else
                    v_q <= v_q + 8'd1;
            end
            else
            begin
                h_q <= h_q + 9'd1;
            end
        end
    end

    ////////////////////
    // Outputs

    assign o_beam.abs_h  = h_q;
    assign o_beam.abs_v  = v_q;
    assign o_beam.flip_h = h_q[7:0] ^ {8{i_hflip}};   // 256H is not flipped here
    assign o_beam.flip_v = v_q ^ {8{i_vflip}};

    // Line counter stays inside the visible count range
    a_h_range : assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
        (o_beam.abs_h >= H_FIRST) && (o_beam.abs_h <= H_LAST));

endmodule

//--- bubsys_mem_timing.sv
`timescale 1ns/1ps

module bubsys_mem_timing
    import bubsys_video_pkg::*;
(
    input  logic        i_EMU_MCLK,
    input  logic        i_arst_n,
    input  logic        i_EMU_CLK18MNCEN_n,
    input  cen_t        i_cen,
    input  logic        i_ref_6m,
    input  logic        i_h0,          // Absolute 1H
    output mem_timing_t o_timing
);

    logic       hf_q;                  // 1HF
    logic [3:0] sr_q;                  // Shift register, QA at bit 3

    // 1HF lags 1H by one pixel
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
            hf_q <= 1'b0;
        else if (!i_cen.clk6m_pcen_n)
            hf_q <= i_h0;
    end

    // 1HF delayed in 18M steps
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
            sr_q <= 4'b1111;           // Keeps CHAMPX high out of reset
        else if (!i_EMU_CLK18MNCEN_n)
        begin
            sr_q[3]   <= hf_q;
            sr_q[2:0] <= sr_q[3:1];
        end
    end

    ////////////////////
    // Strobe decode

    assign o_timing.time1  = ~(~hf_q | i_ref_6m);     // NOR
    assign o_timing.time2  = ~(hf_q & sr_q[2]);       // NAND
    assign o_timing.vrtime = ~(hf_q & ~sr_q[3]);      // NAND
    assign o_timing.champx = sr_q[2] | sr_q[1];       // OR

    // Latch window and write window share one 18M period, then both close
    a_time1_time2 : assert property (@(posedge i_EMU_MCLK) disable iff (!i_arst_n)
        $rose(o_timing.time1) |-> !o_timing.time2 ##2 (o_timing.time2 && !o_timing.time1));

endmodule

//--- bubsys_scroll_ram.sv
`timescale 1ns/1ps

module bubsys_scroll_ram
    import bubsys_video_pkg::*;
(
    input  logic        i_EMU_MCLK,
    input  logic        i_arst_n,
    input  beam_t       i_beam,
    input  logic        i_vclk,            // 1 = horizontal scroll fetch
    input  mem_timing_t i_timing,
    input  cpu_bus_t    i_cpu,
    input  logic        i_vzcs_n,          // Scroll RAM chip select
    output logic [7:0]  o_scroll_cpu_q
);

    bus_owner_e           owner;
    logic                 flip_n256h;
    logic [SCROLL_AW-1:0] scrollval_addr;
    logic [SCROLL_AW-1:0] ram_addr;
    logic                 ram_wr_n;
    logic [7:0]           ram_q;

    logic [7:0] mem [0:(2**SCROLL_AW)-1];

    ////////////////////
    // Address mux

    assign owner      = bus_owner_e'(i_beam.abs_h[0]);    // Odd pixels go to graphics
    assign flip_n256h = ~i_beam.abs_h[8] ^ i_beam.flip_h[7] ^ i_beam.abs_h[7];

    // Scroll value address, no K005291 arithmetic behind it
    always_comb
    begin
        if (i_vclk)
        begin
            // Per-line H scroll
            scrollval_addr = {1'b0, i_beam.abs_h[2], i_beam.abs_h[1], i_beam.flip_v};
        end
        else
        begin
            // Per-column V scroll, 4H picks the layer
            scrollval_addr = {4'b1111, i_beam.abs_h[2], flip_n256h, i_beam.flip_h[7:3]};
        end
    end

    assign ram_addr = (owner == OWNER_GFX) ? scrollval_addr : i_cpu.addr[SCROLL_AW-1:0];

    ////////////////////
    // RAM array

    // Low byte only, write lands in the TIME2 window
    assign ram_wr_n = i_vzcs_n | i_cpu.rw | i_cpu.lds_n | i_timing.time2;

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!ram_wr_n)
            mem[ram_addr] <= i_cpu.wdata[7:0];
        ram_q <= mem[ram_addr];
    end

    // CPU read latch, loads while TIME1 is high
    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_scroll_cpu_q <= 8'h00;
        else if (i_timing.time1)
            o_scroll_cpu_q <= ram_q;       // Last load sees the CPU address
    end

endmodule

//--- bubsys_tile_fetch.sv
`timescale 1ns/1ps

module bubsys_tile_fetch
    import bubsys_video_pkg::*;
(
    input  logic                   i_EMU_MCLK,
    input  logic                   i_arst_n,
    input  beam_t                  i_beam,
    input  cen_t                   i_cen,
    input  mem_timing_t            i_timing,
    input  cpu_bus_t               i_cpu,
    input  logic                   i_vcs1_n,          // VRAM1 chip select
    output logic [DRAM_AW-1:0]     o_dram_addr,
    output logic [TILE_CODE_W-1:0] o_tile_code
);

    logic [VRAM_AW-1:0]     vram_addr;
    logic                   cpu_slot_n;
    logic                   wr_hi_n;
    logic                   wr_lo_n;
    logic [15:0]            vram_q;
    logic                   tile_strobe;
    logic [TILE_CODE_W-1:0] tile_code_q;
    logic                   vvff_q;                     // Tile vertical flip
    logic [2:0]             line_addr;

    logic [15:0] mem [0:(2**VRAM_AW)-1];

    ////////////////////
    // VRAM1

    // Unscrolled beam position, 4H picks the layer half
    assign vram_addr = {i_beam.abs_h[2], i_beam.flip_v[7:3], i_beam.abs_h[8:3]};

    // Byte lane gates, pixels 0 and 4 only
    assign cpu_slot_n = i_vcs1_n | i_cpu.rw | i_beam.abs_h[1] | i_beam.abs_h[0];
    assign wr_hi_n    = cpu_slot_n | i_cpu.uds_n;
    assign wr_lo_n    = cpu_slot_n | i_cpu.lds_n;

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (!wr_hi_n)
            mem[vram_addr][15:8] <= i_cpu.wdata[15:8];
        if (!wr_lo_n)
            mem[vram_addr][7:0] <= i_cpu.wdata[7:0];
        if (!i_timing.vrtime)
            vram_q <= mem[vram_addr];                  // Graphics read window
    end

    ////////////////////
    // Tile code latch

    // Rising edge of inverted 2H, end of pixels 3 and 7
    assign tile_strobe = !i_cen.clk6m_pcen_n && (i_beam.abs_h[1:0] == 2'b11);

    always_ff @(posedge i_EMU_MCLK or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            tile_code_q <= '0;
            vvff_q      <= 1'b0;
        end
        else if (tile_strobe)
        begin
            tile_code_q <= vram_q[TILE_CODE_W-1:0];
            vvff_q      <= vram_q[11];
        end
    end

    ////////////////////
    // DRAM row/column

    assign line_addr = i_beam.flip_v[2:0] ^ {3{vvff_q}};   // Flip inside the tile

    assign o_dram_addr = i_timing.champx ?
                         {tile_code_q[4:0], line_addr} :  // Row
                         {1'b1, tile_code_q[10:5], 1'b1}; // Column

    assign o_tile_code = tile_code_q;

endmodule

//--- bubsys_video.sv
`timescale 1ns/1ps

module bubsys_video
    import bubsys_video_pkg::*;
(
    input  logic                   i_EMU_MCLK,
    input  logic                   i_arst_n,
    input  logic                   i_EMU_CLK18MNCEN_n,
    input  cpu_bus_t               i_cpu,
    input  logic                   i_vzcs_n,
    input  logic                   i_vcs1_n,
    input  logic                   i_vclk,
    input  logic                   i_hflip,
    input  logic                   i_vflip,
    output cen_t                   o_cen,
    output beam_t                  o_beam,
    output mem_timing_t            o_timing,
    output logic [7:0]             o_scroll_cpu_q,
    output logic [DRAM_AW-1:0]     o_dram_addr,
    output logic [TILE_CODE_W-1:0] o_tile_code
);

    logic ref_6m;                      // Divider phase for TIME1

    ////////////////////
    // Timing front end

    bubsys_clock_enables u_clock_enables
    (
        .i_EMU_MCLK         (i_EMU_MCLK),
        .i_arst_n           (i_arst_n),
        .i_EMU_CLK18MNCEN_n (i_EMU_CLK18MNCEN_n),
        .o_cen              (o_cen),
        .o_ref_6m           (ref_6m)
    );

    bubsys_beam_counter u_beam_counter
    (
        .i_EMU_MCLK (i_EMU_MCLK),
        .i_arst_n   (i_arst_n),
        .i_cen      (o_cen),
        .i_hflip    (i_hflip),
        .i_vflip    (i_vflip),
        .o_beam     (o_beam)
    );

    bubsys_mem_timing u_mem_timing
    (
        .i_EMU_MCLK         (i_EMU_MCLK),
        .i_arst_n           (i_arst_n),
        .i_EMU_CLK18MNCEN_n (i_EMU_CLK18MNCEN_n),
        .i_cen              (o_cen),
        .i_ref_6m           (ref_6m),
        .i_h0               (o_beam.abs_h[0]),
        .o_timing           (o_timing)
    );

    ////////////////////
    // RAM side

    bubsys_scroll_ram u_scroll_ram
    (
        .i_EMU_MCLK     (i_EMU_MCLK),
        .i_arst_n       (i_arst_n),
        .i_beam         (o_beam),
        .i_vclk         (i_vclk),
        .i_timing       (o_timing),
        .i_cpu          (i_cpu),
        .i_vzcs_n       (i_vzcs_n),
        .o_scroll_cpu_q (o_scroll_cpu_q)
    );

    bubsys_tile_fetch u_tile_fetch
    (
        .i_EMU_MCLK  (i_EMU_MCLK),
        .i_arst_n    (i_arst_n),
        .i_beam      (o_beam),
        .i_cen       (o_cen),
        .i_timing    (o_timing),
        .i_cpu       (i_cpu),
        .i_vcs1_n    (i_vcs1_n),
        .o_dram_addr (o_dram_addr),
        .o_tile_code (o_tile_code)
    );

endmodule

//--- tb_bubsys_video.sv
`timescale 1ns/1ps

module tb_bubsys_video
    import bubsys_video_pkg::*;
();

    localparam int NTEST = 6;
    localparam int PIX   = 6;          // MCLK per pixel
    localparam int WATCHDOG_NS = (NTEST * 3 * 8 * PIX + 2 * 384 * PIX + 4000) * 20;

    typedef struct packed
    {
        logic [15:0] addr;
        logic [15:0] data;
        logic        hflip;
        logic        vflip;
        logic        vclk;
        logic [15:0] exp_val;          // Scroll uses [7:0] and tile uses [10:0]
    } test_t;

    typedef struct packed
    {
        logic     arst_n;
        logic     vzcs_n;
        logic     vcs1_n;
        logic     vclk;
        logic     hflip;
        logic     vflip;
        cpu_bus_t cpu;
    } drive_t;

    logic clk = 1'b0;
    logic en18_n = 1'b1;
    drive_t drv;
    drive_t nxt;                       // Applied at the next falling edge
    cen_t o_cen;
    beam_t o_beam;
    mem_timing_t o_timing;
    logic [7:0] o_scroll_cpu_q;
    logic [DRAM_AW-1:0] o_dram_addr;
    logic [TILE_CODE_W-1:0] o_tile_code;

    test_t table_q [NTEST];
    logic [31:0] rng;
    logic [8:0] exp_h;                 // Reference beam position
    logic [7:0] exp_v;
    logic pcen;                        // 6M rising strobe seen this cycle
    int test_err, pass_n, fail_n;
    int n9p, n9n, n6p, n6n, nt1, nt2, nvr;

    always #10 clk = ~clk;

    bubsys_video u_bubsys_video
    (
        .i_EMU_MCLK         (clk),
        .i_arst_n           (drv.arst_n),
        .i_EMU_CLK18MNCEN_n (en18_n),
        .i_cpu              (drv.cpu),
        .i_vzcs_n           (drv.vzcs_n),
        .i_vcs1_n           (drv.vcs1_n),
        .i_vclk             (drv.vclk),
        .i_hflip            (drv.hflip),
        .i_vflip            (drv.vflip),
        .o_cen              (o_cen),
        .o_beam             (o_beam),
        .o_timing           (o_timing),
        .o_scroll_cpu_q     (o_scroll_cpu_q),
        .o_dram_addr        (o_dram_addr),
        .o_tile_code        (o_tile_code)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic fail_hex(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
        test_err++;
    endtask

    task automatic report(input string name);
        if (test_err == 0)
        begin
            pass_n++;
            $display("test %s: ok", name);
        end
        else
        begin
            fail_n++;
            $display("test %s: %0d errors", name, test_err);
        end
        test_err = 0;
    endtask

    ////////////////////
    // One MCLK

    task automatic step();
        @(negedge clk);
        en18_n = ~en18_n;              // 18M enable every other MCLK
        drv = nxt;
        #1;                            // Settled well before the rising edge
        if (o_beam.abs_h !== exp_h)
            fail_hex("o_beam.abs_h", 32'(o_beam.abs_h), 32'(exp_h));
        if (o_beam.abs_v !== exp_v)
            fail_hex("o_beam.abs_v", 32'(o_beam.abs_v), 32'(exp_v));
        if (o_beam.flip_h !== (exp_h[7:0] ^ {8{drv.hflip}}))
            fail_hex("o_beam.flip_h", 32'(o_beam.flip_h), 32'(exp_h[7:0] ^ {8{drv.hflip}}));
        if (o_beam.flip_v !== (exp_v ^ {8{drv.vflip}}))
            fail_hex("o_beam.flip_v", 32'(o_beam.flip_v), 32'(exp_v ^ {8{drv.vflip}}));
        pcen = !o_cen.clk6m_pcen_n;
        n9p += int'(!o_cen.clk9m_pcen_n);
        n9n += int'(!o_cen.clk9m_ncen_n);
        n6p += int'(pcen);
        n6n += int'(!o_cen.clk6m_ncen_n);
        if (!en18_n)                   // Once per 18M period
        begin
            nt1 += int'(o_timing.time1);
            nt2 += int'(!o_timing.time2);
            nvr += int'(!o_timing.vrtime);
        end
        if (pcen)                      // Beam moves at this rising edge
        begin
            if (exp_h == H_LAST)
            begin
                exp_h = H_FIRST;
                exp_v = exp_v + 8'd1;
            end
            else
                exp_h = exp_h + 9'd1;
        end
    endtask

    task automatic steps(input int n);
        repeat (n) step();
    endtask

    // Run until the given pixel ends
    task automatic wait_pixel(input logic [2:0] pix);
        step();
        while (!(pcen && o_beam.abs_h[2:0] == pix))
            step();
    endtask

    task automatic scroll_test(input int i);
        test_t t;
        t = table_q[i];
        nxt.cpu = '{addr: t.addr, wdata: t.data, rw: 1'b0, uds_n: 1'b1, lds_n: 1'b0};
        nxt.vzcs_n = 1'b0;
        nxt.vclk = t.vclk;
        steps(8 * PIX);                // Whole 8 pixel group
        nxt.cpu.rw = 1'b1;
        nxt.cpu.wdata = ~t.data;       // Bus data must not leak into the read
        steps(8 * PIX);
        if (o_scroll_cpu_q !== t.exp_val[7:0])
            fail_hex("o_scroll_cpu_q", 32'(o_scroll_cpu_q), 32'(t.exp_val[7:0]));
        nxt.vzcs_n = 1'b1;
        steps(2);
        report($sformatf("scroll %0d addr %h", i, t.addr[10:0]));
    endtask

    task automatic vram_test(input int i);
        test_t t;
        logic seen_row;
        logic seen_col;
        logic done;
        logic [7:0] want;
        t = table_q[i];
        seen_row = 1'b0;
        seen_col = 1'b0;
        nxt.hflip = t.hflip;
        nxt.vflip = t.vflip;
        wait_pixel(3'd7);              // Next pixel starts a column group
        nxt.cpu = '{addr: t.addr, wdata: t.data, rw: 1'b0, uds_n: 1'b0, lds_n: 1'b0};
        nxt.vcs1_n = 1'b0;
        wait_pixel(3'd3);              // Tile latch at the end of pixel 3
        step();
        if (o_tile_code !== t.exp_val[10:0])
            fail_hex("o_tile_code", 32'(o_tile_code), 32'(t.exp_val[10:0]));
        done = 1'b0;
        while (!done)
        begin
            // Row form is code low bits then line in tile flipped by bit 11
            if (o_timing.champx)
                want = {t.data[4:0], exp_v[2:0] ^ {3{t.vflip}} ^ {3{t.data[11]}}};
            else
                want = {1'b1, t.data[10:5], 1'b1};
            seen_row |= o_timing.champx;
            seen_col |= !o_timing.champx;
            if (o_dram_addr !== want)
                fail_hex("o_dram_addr", 32'(o_dram_addr), 32'(want));
            done = pcen && (o_beam.abs_h[2:0] == 3'd7);
            if (!done)
                step();
        end
        if (!seen_row || !seen_col)
        begin
            $display("DRAM address did not show both row and column forms");
            test_err++;
        end
        nxt.cpu.rw = 1'b1;
        nxt.vcs1_n = 1'b1;
        step();
        report($sformatf("vram %0d col %h flips %b%b", i, exp_h[8:3], t.hflip, t.vflip));
    endtask

    ////////////////////
    // Watchdog

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    ////////////////////
    // Main sequence

    initial
    begin
        logic [7:0] start_v;
        int n;
        nxt = '0;
        nxt.vzcs_n = 1'b1;
        nxt.vcs1_n = 1'b1;
        nxt.cpu = '{addr: 16'h0, wdata: 16'h0, rw: 1'b1, uds_n: 1'b1, lds_n: 1'b1};
        drv = nxt;                     // Reset asserted from time zero
        exp_h = H_FIRST;
        exp_v = 8'd0;
        rng = 32'd79286;
        {test_err, pass_n, fail_n} = '0;
        {n9p, n9n, n6p, n6n, nt1, nt2, nvr} = '0;
        for (int i = 0; i < NTEST; i++)
        begin
            rng = xorshift(rng);
            table_q[i] = '{addr: {5'd0, rng[10:0]}, data: rng[31:16], hflip: i[0],
                           vflip: i[1], vclk: rng[11], exp_val: rng[31:16]};
        end

        repeat (8)                     // 8 cycles of reset
        begin
            step();
            if (o_cen !== 4'hf)
                fail_hex("o_cen", 32'(o_cen), 32'hf);
        end
        nxt.arst_n = 1'b1;
        steps(10);
        report("reset");

        {n9p, n9n, n6p, n6n} = '0;
        steps(1200);                   // 600 enables of 18M
        if (n9p != 300)
            fail_hex("9M pcen count", 32'(n9p), 32'd300);   // 3 of 6 phases
        if (n9n != 300)
            fail_hex("9M ncen count", 32'(n9n), 32'd300);
        if (n6p != 200)
            fail_hex("6M pcen count", 32'(n6p), 32'd200);   // 2 of 6 phases
        if (n6n != 200)
            fail_hex("6M ncen count", 32'(n6n), 32'd200);
        report("clock enables");

        {nt1, nt2, nvr} = '0;
        steps(8 * PIX);                // One strobe each per pixel pair
        if (nt1 != 4)
            fail_hex("TIME1 high periods", 32'(nt1), 32'd4);
        if (nt2 != 4)
            fail_hex("TIME2 low periods", 32'(nt2), 32'd4);
        if (nvr != 4)
            fail_hex("VRTIME low periods", 32'(nvr), 32'd4);
        report("memory timing");

        // Flips cycle through all four settings on the way to the line wrap
        start_v = exp_v;
        n = 0;
        while (exp_v == start_v)
        begin
            nxt.hflip = n[7];
            nxt.vflip = n[8];
            step();
            n++;
        end
        step();                        // First pixel of the new line
        if (o_beam.abs_h !== H_FIRST)
            fail_hex("o_beam.abs_h", 32'(o_beam.abs_h), 32'(H_FIRST));
        if (o_beam.abs_v !== start_v + 8'd1)
            fail_hex("o_beam.abs_v", 32'(o_beam.abs_v), 32'(start_v + 8'd1));
        report("beam counter");

        for (int i = 0; i < NTEST; i++)
        begin
            scroll_test(i);
            vram_test(i);
        end

        $display("tests: %0d ok, %0d with errors", pass_n, fail_n);
        if (fail_n == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- bubsys_video.f
bubsys_video_pkg.sv
bubsys_clock_enables.sv
bubsys_beam_counter.sv
bubsys_mem_timing.sv
bubsys_scroll_ram.sv
bubsys_tile_fetch.sv
bubsys_video.sv
tb_bubsys_video.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bubsys_video
FILELIST  ?= bubsys_video.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
